//--- sim.f
source/sort_pru_pkg.sv
source/cnt_read_sequencer.sv
source/bank_compactor.sv
source/prefetch_queue.sv
source/port_issuer.sv
source/sort_pru.sv
verif/sort_pru_tb.sv

//--- Makefile
SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vsort_pru_tb
	obj_dir/Vsort_pru_tb > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if grep -q "Regression failed" sim.log; then exit 1; fi; \
	exit $$status

obj_dir/Vsort_pru_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -Wall --top-module sort_pru_tb -f sim.f

clean:
	rm -rf obj_dir sim.log

//--- verif/sort_pru_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sort_pru_tb;

    localparam int VALUES       = 64;
    localparam int BANKS        = 4;
    localparam int ROWS         = 16;
    localparam int CNT_BITS     = 4;
    localparam int IDX_BITS     = 6;
    localparam int NUM_TESTS    = 7;
    localparam int DONE_TIMEOUT = 4000;
    localparam int QUIET_CYCLES = 10;
    localparam int RESTART_AT   = 20;

    localparam int FILL_ZERO   = 0;
    localparam int FILL_ONE    = 1;
    localparam int FILL_REPEAT = 2;
    localparam int FILL_RANDOM = 3;

    logic                         clk;
    logic                         rst_n;
    logic                         ctrl2pru_start_vld;
    logic                         ctrl2pru_config_oder_en;
    logic                         cnt2pru_rd_vld;
    logic [3:0]                   cnt2pru_rd_addr;
    logic [BANKS*CNT_BITS-1:0]    cnt2pru_rd_data;
    logic                         pru2cnt_rd_vld;
    logic [3:0]                   pru2cnt_rd_addr;
    logic                         pru2ctrl_rd_done_vld;
    logic [1:0]                   pru2output_data_vld;
    logic [2*IDX_BITS-1:0]        pru2output_data;

    // test table: name, order flag, fill kind, second start during the scan
    string test_name    [NUM_TESTS] = '{"all_zero", "scattered_asc", "repeat_asc",
                                        "scattered_desc", "random_asc", "random_desc",
                                        "restart_ignored"};
    logic  test_order   [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
    int    test_fill    [NUM_TESTS] = '{FILL_ZERO, FILL_ONE, FILL_REPEAT, FILL_ONE,
                                        FILL_RANDOM, FILL_RANDOM, FILL_RANDOM};
    logic  test_restart [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic [BANKS*CNT_BITS-1:0] mem_rows [ROWS];
    logic [IDX_BITS-1:0]       exp_q [$];
    logic [31:0]               fill_seed;
    int                        errors;
    int                        n_out;
    logic                      dual_seen;
    int                        pass_cnt;
    int                        fail_cnt;
    logic                      abort;

    sort_pru u_sort_pru (
        .clk                       (clk),
        .rst_n_i                   (rst_n),
        .ctrl2pru_start_vld_i      (ctrl2pru_start_vld),
        .ctrl2pru_config_oder_en_i (ctrl2pru_config_oder_en),
        .cnt2pru_rd_vld_i          (cnt2pru_rd_vld),
        .cnt2pru_rd_addr_i         (cnt2pru_rd_addr),
        .cnt2pru_rd_data_i         (cnt2pru_rd_data),
        .pru2cnt_rd_vld_o          (pru2cnt_rd_vld),
        .pru2cnt_rd_addr_o         (pru2cnt_rd_addr),
        .pru2ctrl_rd_done_vld_o    (pru2ctrl_rd_done_vld),
        .pru2output_data_vld_o     (pru2output_data_vld),
        .pru2output_data_o         (pru2output_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // count memory, answers one request after 1 to 3 cycles
    initial begin : count_memory
        logic [31:0] lat_seed;
        int          delay_left;
        logic        pending;
        logic [3:0]  req_addr;
        lat_seed        = 32'd10;
        delay_left      = 0;
        pending         = 1'b0;
        req_addr        = '0;
        cnt2pru_rd_vld  = 1'b0;
        cnt2pru_rd_addr = '0;
        cnt2pru_rd_data = '0;
        forever begin
            @(negedge clk);
            cnt2pru_rd_vld = 1'b0;
            if (pending) begin
                delay_left = delay_left - 1;
                if (delay_left == 0) begin
                    cnt2pru_rd_vld  = 1'b1;
                    cnt2pru_rd_addr = req_addr;
                    cnt2pru_rd_data = mem_rows[req_addr];
                    pending         = 1'b0;
                end
            end else if (rst_n && pru2cnt_rd_vld) begin
                pending    = 1'b1;
                req_addr   = pru2cnt_rd_addr;
                lat_seed   = xorshift32(lat_seed);
                delay_left = 1 + int'(lat_seed % 32'd3);
            end
        end
    end

    task automatic fill_memory(input int kind);
        logic [CNT_BITS-1:0] cnt;
        for (int r = 0; r < ROWS; r++) begin
            for (int b = 0; b < BANKS; b++) begin
                cnt = '0;
                case (kind)
                    FILL_ONE: begin
                        if ((r * BANKS + b) % 7 == 3) begin
                            cnt = 4'd1;
                        end
                    end
                    FILL_REPEAT: begin
                        // counts 2 to 15 on bank 1 of rows 0 to 13
                        if (b == 1 && r < 14) begin
                            cnt = CNT_BITS'(r + 2);
                        end
                    end
                    FILL_RANDOM: begin
                        fill_seed = xorshift32(fill_seed);
                        cnt       = fill_seed[7:4];
                    end
                    default: cnt = '0;
                endcase
                mem_rows[r][b*CNT_BITS +: CNT_BITS] = cnt;
            end
        end
    endtask

    // every index repeated by its count, in the requested order
    task automatic build_expected(input logic desc);
        int idx;
        int reps;
        exp_q.delete();
        for (int k = 0; k < VALUES; k++) begin
            idx  = desc ? VALUES - 1 - k : k;
            reps = int'(mem_rows[idx/BANKS][(idx%BANKS)*CNT_BITS +: CNT_BITS]);
            for (int n = 0; n < reps; n++) begin
                exp_q.push_back(IDX_BITS'(idx));
            end
        end
    endtask

    task automatic compare_ports(input string name);
        logic [IDX_BITS-1:0] got;
        logic [IDX_BITS-1:0] want;
        for (int p = 0; p < 2; p++) begin
            if (pru2output_data_vld[p]) begin
                got   = pru2output_data[p*IDX_BITS +: IDX_BITS];
                n_out = n_out + 1;
                assert (exp_q.size() > 0) else begin
                    $display("%s: port %0d issued more indices than expected", name, p);
                    errors = errors + 1;
                end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (got == want) else begin
                        $display("[FAIL] %s pru2output_data_o[%0d]: expected 0x%0h, actual 0x%0h",
                                 name, p, want, got);
                        errors = errors + 1;
                    end
                end
            end
        end
        if (&pru2output_data_vld && pru2output_data[5:0] == pru2output_data[11:6]) begin
            dual_seen = 1'b1;
        end
    endtask

    task automatic run_test(input int t);
        int   cycles;
        logic done_seen;
        fill_memory(test_fill[t]);
        build_expected(test_order[t]);
        errors    = 0;
        n_out     = 0;
        dual_seen = 1'b0;
        @(negedge clk);
        ctrl2pru_start_vld      = 1'b1;
        ctrl2pru_config_oder_en = test_order[t];
        @(negedge clk);
        ctrl2pru_start_vld = 1'b0;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < DONE_TIMEOUT) begin
            compare_ports(test_name[t]);
            done_seen = pru2ctrl_rd_done_vld;
            // a second start with the other order must change nothing
            ctrl2pru_start_vld      = test_restart[t] && (cycles == RESTART_AT);
            ctrl2pru_config_oder_en = test_order[t] ^ ctrl2pru_start_vld;
            @(negedge clk);
            cycles = cycles + 1;
        end
        ctrl2pru_start_vld = 1'b0;
        assert (done_seen) else begin
            $display("%s: no done pulse within %0d cycles", test_name[t], DONE_TIMEOUT);
            errors = errors + 1;
            abort  = 1'b1;
        end
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected indices never came out", test_name[t], exp_q.size());
            errors = errors + 1;
        end
        if (test_fill[t] == FILL_REPEAT) begin
            assert (dual_seen) else begin
                $display("%s: no cycle issued one index on both ports", test_name[t]);
                errors = errors + 1;
            end
        end
        for (int q = 0; q < QUIET_CYCLES; q++) begin
            assert (pru2output_data_vld == 2'b00) else begin
                $display("%s: output valid after the done pulse", test_name[t]);
                errors = errors + 1;
            end
            @(negedge clk);
        end
        if (errors == 0) begin
            pass_cnt = pass_cnt + 1;
            $display("test %-16s ok, %0d indices", test_name[t], n_out);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %-16s has %0d errors", test_name[t], errors);
        end
    endtask

    initial begin
        rst_n                   = 1'b0;
        ctrl2pru_start_vld      = 1'b0;
        ctrl2pru_config_oder_en = 1'b0;
        fill_seed               = 32'd10;
        pass_cnt                = 0;
        fail_cnt                = 0;
        abort                   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS && !abort; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !abort) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/sort_pru.sv
`timescale 1ns/10ps
`default_nettype none

module sort_pru (
    input  wire logic                                                 clk,
    input  wire logic                                                 rst_n_i,
    input  wire logic                                                 ctrl2pru_start_vld_i,
    input  wire logic                                                 ctrl2pru_config_oder_en_i,
    input  wire logic                                                 cnt2pru_rd_vld_i,
    input  wire sort_pru_pkg::row_t                                   cnt2pru_rd_addr_i,
    input  wire logic [sort_pru_pkg::BK_NUM*sort_pru_pkg::CNT_W-1:0]  cnt2pru_rd_data_i,
    output logic                                                      pru2cnt_rd_vld_o,
    output sort_pru_pkg::row_t                                        pru2cnt_rd_addr_o,
    output logic                                                      pru2ctrl_rd_done_vld_o,
    output logic [sort_pru_pkg::OUT_NUM-1:0]                          pru2output_data_vld_o,
    output logic [sort_pru_pkg::OUT_NUM*sort_pru_pkg::DATA_W-1:0]     pru2output_data_o
);

    import sort_pru_pkg::*;

    logic                               order_lat;
    entry_t [BK_NUM-1:0]                wr_entries;
    logic [BK_W:0]                      wr_num;
    entry_t [OUT_NUM-1:0]               head;
    logic [OCC_W-1:0]                   occ;
    logic [$clog2(OUT_NUM+1)-1:0]       pop_num;
    logic [OUT_NUM-1:0]                 wb_vld;
    entry_t [OUT_NUM-1:0]               wb_entries;

    cnt_read_sequencer u_cnt_read_sequencer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (ctrl2pru_start_vld_i),
        .order_i      (ctrl2pru_config_oder_en_i),
        .rd_ret_vld_i (cnt2pru_rd_vld_i),
        .occ_i        (occ),
        .rd_vld_o     (pru2cnt_rd_vld_o),
        .rd_addr_o    (pru2cnt_rd_addr_o),
        .order_o      (order_lat),
        .done_o       (pru2ctrl_rd_done_vld_o)
    );

    // row index comes from the echoed address
    bank_compactor u_bank_compactor (
        .rd_vld_i     (cnt2pru_rd_vld_i),
        .rd_addr_i    (cnt2pru_rd_addr_i),
        .rd_data_i    (cnt2pru_rd_data_i),
        .order_i      (order_lat),
        .wr_entries_o (wr_entries),
        .wr_num_o     (wr_num)
    );

    prefetch_queue u_prefetch_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_entries_i (wr_entries),
        .wr_num_i     (wr_num),
        .pop_num_i    (pop_num),
        .wb_vld_i     (wb_vld),
        .wb_entries_i (wb_entries),
        .head_o       (head),
        .occ_o        (occ)
    );

    port_issuer u_port_issuer (
        .head_i       (head),
        .occ_i        (occ),
        .out_vld_o    (pru2output_data_vld_o),
        .out_data_o   (pru2output_data_o),
        .pop_num_o    (pop_num),
        .wb_vld_o     (wb_vld),
        .wb_entries_o (wb_entries)
    );

endmodule

`default_nettype wire

//--- source/port_issuer.sv
`timescale 1ns/10ps
`default_nettype none

module port_issuer (
    input  wire sort_pru_pkg::entry_t [sort_pru_pkg::OUT_NUM-1:0]    head_i,
    input  wire logic [sort_pru_pkg::OCC_W-1:0]                      occ_i,
    output logic [sort_pru_pkg::OUT_NUM-1:0]                         out_vld_o,
    output logic [sort_pru_pkg::OUT_NUM*sort_pru_pkg::DATA_W-1:0]    out_data_o,
    output logic [$clog2(sort_pru_pkg::OUT_NUM+1)-1:0]               pop_num_o,
    output logic [sort_pru_pkg::OUT_NUM-1:0]                         wb_vld_o,
    output sort_pru_pkg::entry_t [sort_pru_pkg::OUT_NUM-1:0]         wb_entries_o
);

    import sort_pru_pkg::*;

    cnt_t cnt0;
    cnt_t cnt1;
    cnt_t use0;
    logic head0_vld;
    logic head0_dup;
    logic head1_vld;
    logic pop0;
    logic pop1;

    assign cnt0 = head_i[0].cnt;
    assign cnt1 = head_i[1].cnt;

    // port 1 repeats head 0 if it has count left, else takes head 1
    assign head0_vld = (occ_i != '0);
    assign head0_dup = head0_vld && (cnt0 >= cnt_t'(2));
    assign head1_vld = head0_vld && (cnt0 == cnt_t'(1)) && (occ_i > OCC_W'(1));

    assign out_vld_o[0] = head0_vld;
    assign out_vld_o[1] = head0_dup || head1_vld;

    assign out_data_o[DATA_W-1:0]        = head_i[0].idx;
    assign out_data_o[2*DATA_W-1:DATA_W] = head1_vld ? head_i[1].idx : head_i[0].idx;

    // an entry is popped once all its repeats are issued
    assign use0 = cnt_t'(head0_vld) + cnt_t'(head0_dup);
    assign pop0 = head0_vld && (use0 == cnt0);
    assign pop1 = head1_vld && (cnt1 == cnt_t'(1));

    assign pop_num_o = {1'b0, pop0} + {1'b0, pop1};

    // partly used entries go back with what is left
    assign wb_vld_o[0]         = head0_vld && !pop0;
    assign wb_entries_o[0].idx = head_i[0].idx;
    assign wb_entries_o[0].cnt = cnt0 - use0;

    assign wb_vld_o[1]         = head1_vld && !pop1;
    assign wb_entries_o[1].idx = head_i[1].idx;
    assign wb_entries_o[1].cnt = cnt1 - cnt_t'(1);

    // every issued head entry still has repeats left
    always_comb begin
        a_head_cnt: assert (!(head0_vld && cnt0 == '0) && !(head1_vld && cnt1 == '0))
            else $error("issued head entry with zero count");
    end

endmodule

`default_nettype wire

//--- source/prefetch_queue.sv
`timescale 1ns/10ps
`default_nettype none

module prefetch_queue (
    input  wire logic                                            clk,
    input  wire logic                                            rst_n_i,
    input  wire sort_pru_pkg::entry_t [sort_pru_pkg::BK_NUM-1:0] wr_entries_i,
    input  wire logic [sort_pru_pkg::BK_W:0]                     wr_num_i,
    input  wire logic [$clog2(sort_pru_pkg::OUT_NUM+1)-1:0]      pop_num_i,
    input  wire logic [sort_pru_pkg::OUT_NUM-1:0]                wb_vld_i,
    input  wire sort_pru_pkg::entry_t [sort_pru_pkg::OUT_NUM-1:0] wb_entries_i,
    output sort_pru_pkg::entry_t [sort_pru_pkg::OUT_NUM-1:0]     head_o,
    output logic [sort_pru_pkg::OCC_W-1:0]                       occ_o
);

    import sort_pru_pkg::*;

    entry_t           mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [OCC_W-1:0] occ_q;
    logic [PTR_W-1:0] wr_slot [BK_NUM];
    logic [PTR_W-1:0] wb_slot [OUT_NUM];

    // slot addresses wrap with the pointer width
    always_comb begin
        for (int i = 0; i < BK_NUM; i++) begin
            wr_slot[i] = wr_ptr_q + PTR_W'(i);
        end
        for (int p = 0; p < OUT_NUM; p++) begin
            wb_slot[p] = rd_ptr_q + PTR_W'(p);
        end
    end

    // new rows land in free slots, write-backs hit the occupied head slots
    always_ff @(posedge clk) begin
        for (int i = 0; i < BK_NUM; i++) begin
            if (i < int'(wr_num_i)) begin
                mem_q[wr_slot[i]] <= wr_entries_i[i];
            end
        end
        for (int p = 0; p < OUT_NUM; p++) begin
            if (wb_vld_i[p]) begin
                mem_q[wb_slot[p]] <= wb_entries_i[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            occ_q    <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(wr_num_i);
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_num_i);
            occ_q    <= occ_q + OCC_W'(wr_num_i) - OCC_W'(pop_num_i);
        end
    end

    always_comb begin
        for (int p = 0; p < OUT_NUM; p++) begin
            head_o[p] = mem_q[wb_slot[p]];
        end
    end

    assign occ_o = occ_q;

    // relies on the sequencer's free-space check before each read
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        occ_q <= OCC_W'(DEPTH)
    ) else $error("prefetch queue overflow, occupancy %0d", occ_q);

endmodule

`default_nettype wire

//--- source/bank_compactor.sv
`timescale 1ns/10ps
`default_nettype none

module bank_compactor (
    input  wire logic                                                   rd_vld_i,
    input  wire sort_pru_pkg::row_t                                     rd_addr_i,
    input  wire logic [sort_pru_pkg::BK_NUM*sort_pru_pkg::CNT_W-1:0]    rd_data_i,
    input  wire logic                                                   order_i,
    output sort_pru_pkg::entry_t [sort_pru_pkg::BK_NUM-1:0]             wr_entries_o,
    output logic [sort_pru_pkg::BK_W:0]                                 wr_num_o
);

    import sort_pru_pkg::*;

    int         nz_num;
    logic [BK_W-1:0] bank;
    cnt_t       bank_cnt;

    // walk the banks in output order and pack the non-zero ones low
    always_comb begin
        wr_entries_o = '0;
        nz_num       = 0;
        bank         = '0;
        bank_cnt     = '0;
        for (int k = 0; k < BK_NUM; k++) begin
            bank     = order_i ? BK_W'(BK_NUM - 1 - k) : BK_W'(k);
            bank_cnt = rd_data_i[int'(bank)*CNT_W +: CNT_W];
            if (bank_cnt != '0) begin
                wr_entries_o[nz_num].idx = {rd_addr_i, bank};
                wr_entries_o[nz_num].cnt = bank_cnt;
                nz_num                   = nz_num + 1;
            end
        end
    end

    // nothing is written without a returned row
    assign wr_num_o = rd_vld_i ? (BK_W+1)'(nz_num) : '0;

endmodule

`default_nettype wire

//--- source/cnt_read_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cnt_read_sequencer (
    input  wire logic                              clk,
    input  wire logic                              rst_n_i,
    input  wire logic                              start_i,
    input  wire logic                              order_i,
    input  wire logic                              rd_ret_vld_i,
    input  wire logic [sort_pru_pkg::OCC_W-1:0]    occ_i,
    output logic                                   rd_vld_o,
    output sort_pru_pkg::row_t                     rd_addr_o,
    output logic                                   order_o,
    output logic                                   done_o
);

    import sort_pru_pkg::*;

    seq_state_t       state_q;
    row_t             row_q;
    logic             order_q;
    logic [OCC_W-1:0] free_space;
    logic             last_row;

    assign free_space = OCC_W'(DEPTH) - occ_i;

    // descending scans start at the top row and end at row 0
    assign last_row = order_q ? (row_q == '0) : (row_q == row_t'(ROW_NUM - 1));

    // a row may hold up to BK_NUM non-zero banks
    assign rd_vld_o  = (state_q == READ) && (free_space >= OCC_W'(BK_NUM));
    assign rd_addr_o = row_q;
    assign order_o   = order_q;
    assign done_o    = (state_q == DRAIN) && (occ_i == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            row_q   <= '0;
            order_q <= 1'b0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (start_i) begin
                        order_q <= order_i;
                        row_q   <= order_i ? row_t'(ROW_NUM - 1) : '0;
                        state_q <= READ;
                    end
                end
                READ: begin
                    if (rd_vld_o) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (rd_ret_vld_i) begin
                        if (last_row) begin
                            state_q <= DRAIN;
                        end else begin
                            row_q   <= order_q ? row_q - row_t'(1) : row_q + row_t'(1);
                            state_q <= READ;
                        end
                    end
                end
                DRAIN: begin
                    if (done_o) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // a row comes back only while its request is outstanding
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        rd_ret_vld_i |-> (state_q == WAIT)
    ) else $error("row returned with no read outstanding");

    // queue stays empty once done is seen
    a_done_drained: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        done_o |=> (occ_i == '0)
    ) else $error("queue written after the done pulse");

endmodule

`default_nettype wire

//--- source/sort_pru_pkg.sv
`default_nettype none

package sort_pru_pkg;

    // value range and count memory shape
    localparam int MAX_NUM = 64;
    localparam int BK_NUM  = 4;
    localparam int ROW_NUM = MAX_NUM / BK_NUM;
    localparam int ROW_W   = 4;
    localparam int BK_W    = 2;

    localparam int DATA_W  = 6;
    localparam int CNT_W   = 4;

    // prefetch queue
    localparam int DEPTH   = 8;
    localparam int PTR_W   = 3;
    localparam int OCC_W   = PTR_W + 1;

    localparam int OUT_NUM = 2;

    typedef logic [DATA_W-1:0] idx_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [ROW_W-1:0]  row_t;

    // one queue slot, index above its remaining repeat count
    typedef struct packed {
        idx_t idx;
        cnt_t cnt;
    } entry_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT,
        DRAIN
    } seq_state_t;

endpackage

`default_nettype wire
